// File: hw/rswaf_pkg.sv
package rswaf_pkg;

  // Q4.12 is used by every stage
  localparam int DATA_W    = 16;
  localparam int FRAC_BITS = 12;

  // Signed input sample
  typedef logic signed [DATA_W-1:0] sample_t;

  // Unsigned magnitude and sech2 result
  typedef logic [DATA_W-1:0] mag_t;

  // x - grid needs one extra bit
  localparam int DIFF_W = DATA_W + 1;

  // Full width of difference times scale
  localparam int PROD_W = DIFF_W + DATA_W;

  // Input buffering per stream
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

  // Table covers magnitudes below 4.0 in steps of 1/16
  localparam int LUT_ADDR_W = 6;
  localparam int LUT_DEPTH  = 64;

  // Relative to the directory the simulator runs in
  localparam string LUT_FILE = "hw/sech2_table.mem";

endpackage

// File: hw/axis_if.sv
interface axis_if
  import rswaf_pkg::*;
();

  // One Q4.12 word per transfer
  logic [DATA_W-1:0] data;
  logic              valid;
  logic              ready;
  logic              last;

  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// File: hw/stream_fifo.sv
module stream_fifo
  import rswaf_pkg::*;
(
  input logic    clk,
  input logic    reset,
  axis_if.sink   in_s,
  axis_if.source out_s
);

  // Each entry keeps last above the data word
  logic [DATA_W:0]       mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  out_valid;
  logic [DATA_W-1:0]     out_data;
  logic                  out_last;
  logic                  push;
  logic                  pop;

  assign in_s.ready = (count < FIFO_CNT_W'(FIFO_DEPTH));
  assign push       = in_s.valid && in_s.ready;

  // Refill the output register when it is empty or being taken
  assign pop = (count != '0) && (!out_valid || out_s.ready);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_s.last, in_s.data};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      if (pop) begin
        out_valid <= 1'b1;
      end else if (out_s.ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      {out_last, out_data} <= mem[rd_ptr];
    end
  end

  assign out_s.valid = out_valid;
  assign out_s.data  = out_data;
  assign out_s.last  = out_last;

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= FIFO_CNT_W'(FIFO_DEPTH));

  // Offered item is held until the consumer takes it
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_s.ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

// File: hw/scaled_diff.sv
module scaled_diff
  import rswaf_pkg::*;
(
  input logic    clk,
  input logic    reset,
  axis_if.sink   data_s,
  axis_if.sink   grid_s,
  axis_if.sink   scale_s,
  axis_if.source diff_s
);

  // Stage 1 registers
  logic                     s1_valid;
  logic                     s1_last;
  logic signed [DIFF_W-1:0] s1_diff;
  sample_t                  s1_scale;

  // Stage 2 registers
  logic                     s2_valid;
  logic                     s2_last;
  mag_t                     s2_mag;

  logic                     s1_ready;
  logic                     s2_ready;
  logic                     take_all;
  logic signed [DIFF_W-1:0] x_minus_grid;
  logic signed [PROD_W-1:0] product;
  logic signed [PROD_W-1:0] shifted;
  logic        [PROD_W-1:0] magnitude;
  mag_t                     sat_mag;

  // A stage advances when its register is empty or being taken
  assign s2_ready = !s2_valid || diff_s.ready;
  assign s1_ready = !s1_valid || s2_ready;

  // Join one item from each queue, all on the same edge
  assign take_all = data_s.valid && grid_s.valid && scale_s.valid && s1_ready;

  assign data_s.ready  = take_all;
  assign grid_s.ready  = take_all;
  assign scale_s.ready = take_all;

  // Sign extend both operands by one bit
  assign x_minus_grid = {data_s.data[DATA_W-1], data_s.data}
                      - {grid_s.data[DATA_W-1], grid_s.data};

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= take_all;
    end
  end

  always_ff @(posedge clk) begin
    if (take_all) begin
      s1_diff  <= x_minus_grid;
      s1_scale <= scale_s.data;
      s1_last  <= data_s.last;
    end
  end

  // Q4.12 times Q4.12 floored back to 12 fractional bits
  assign product = s1_diff * s1_scale;
  assign shifted = product >>> FRAC_BITS;

  assign magnitude = shifted[PROD_W-1] ? -shifted : shifted;

  // Clip to the largest 16-bit magnitude
  assign sat_mag = (|magnitude[PROD_W-1:DATA_W]) ? '1 : magnitude[DATA_W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (s2_ready) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready && s1_valid) begin
      s2_mag  <= sat_mag;
      s2_last <= s1_last;
    end
  end

  assign diff_s.valid = s2_valid;
  assign diff_s.data  = s2_mag;
  assign diff_s.last  = s2_last;

  // Stage 2 keeps its item while the lookup stalls
  a_diff_stable: assert property (@(posedge clk) disable iff (reset)
    diff_s.valid && !diff_s.ready |=> diff_s.valid && $stable(diff_s.data)
      && $stable(diff_s.last));

endmodule

// File: hw/sech2_lut.sv
module sech2_lut
  import rswaf_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  axis_if.sink  diff_s,
  output mag_t  result_data,
  output logic  result_valid,
  input  logic  result_ready,
  output logic  result_last
);

  mag_t                  lut_rom [LUT_DEPTH];
  logic [LUT_ADDR_W-1:0] lut_addr;
  logic                  over_range;
  mag_t                  lut_value;
  logic                  take;

  initial begin
    $readmemh(LUT_FILE, lut_rom);
  end

  // Output register holds one item under stall
  assign diff_s.ready = !result_valid || result_ready;
  assign take         = diff_s.valid && diff_s.ready;

  // Magnitudes of 4.0 and above fall off the table
  assign over_range = |diff_s.data[DATA_W-1:DATA_W-2];

  // Step of 1/16 in Q4.12
  assign lut_addr  = diff_s.data[FRAC_BITS+1 -: LUT_ADDR_W];
  assign lut_value = over_range ? '0 : lut_rom[lut_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (take) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      result_data <= lut_value;
      result_last <= diff_s.last;
    end
  end

  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result_data)
      && $stable(result_last));

endmodule

// File: hw/rswaf_function.sv
module rswaf_function
  import rswaf_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  sample_t data_data,
  input  logic    data_valid,
  output logic    data_ready,
  input  logic    data_last,
  input  sample_t grid_data,
  input  logic    grid_valid,
  output logic    grid_ready,
  input  logic    grid_last,
  input  sample_t scale_data,
  input  logic    scale_valid,
  output logic    scale_ready,
  input  logic    scale_last,
  output mag_t    result_data,
  output logic    result_valid,
  input  logic    result_ready,
  output logic    result_last
);

  // Input side of each FIFO
  axis_if data_in ();
  axis_if grid_in ();
  axis_if scale_in ();

  // FIFO to pipeline
  axis_if data_q ();
  axis_if grid_q ();
  axis_if scale_q ();

  // Pipeline to lookup
  axis_if diff_s ();

  assign data_in.data  = data_data;
  assign data_in.valid = data_valid;
  assign data_in.last  = data_last;
  assign data_ready    = data_in.ready;

  assign grid_in.data  = grid_data;
  assign grid_in.valid = grid_valid;
  assign grid_in.last  = grid_last;
  assign grid_ready    = grid_in.ready;

  assign scale_in.data  = scale_data;
  assign scale_in.valid = scale_valid;
  assign scale_in.last  = scale_last;
  assign scale_ready    = scale_in.ready;

  stream_fifo data_fifo  (.clk(clk), .reset(reset), .in_s(data_in),  .out_s(data_q));
  stream_fifo grid_fifo  (.clk(clk), .reset(reset), .in_s(grid_in),  .out_s(grid_q));
  stream_fifo scale_fifo (.clk(clk), .reset(reset), .in_s(scale_in), .out_s(scale_q));

  scaled_diff scaled_diff (
    .clk     (clk),
    .reset   (reset),
    .data_s  (data_q),
    .grid_s  (grid_q),
    .scale_s (scale_q),
    .diff_s  (diff_s)
  );

  sech2_lut sech2_lut (
    .clk          (clk),
    .reset        (reset),
    .diff_s       (diff_s),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_last  (result_last)
  );

endmodule

// File: bench/tb_rswaf_function.sv
module tb_rswaf_function
  import rswaf_pkg::*;
();

  localparam int MAX_ITEMS = 1024;

  logic        clk;
  logic        reset;
  sample_t     in_data [3];
  logic [2:0]  in_valid;
  logic [2:0]  in_last;
  wire  [2:0]  in_ready;
  mag_t        result_data;
  logic        result_valid;
  logic        result_ready;
  logic        result_last;

  // Stimulus and expected results per item
  sample_t     x_vals    [MAX_ITEMS];
  sample_t     g_vals    [MAX_ITEMS];
  sample_t     s_vals    [MAX_ITEMS];
  logic        last_vals [MAX_ITEMS];
  mag_t        exp_vals  [MAX_ITEMS];
  mag_t        lut_model [LUT_DEPTH];

  logic [31:0] rng_state;
  int          sent [3];
  logic [2:0]  held;
  int          recv;
  logic        saw_full;

  rswaf_function dut (
    .clk          (clk),
    .reset        (reset),
    .data_data    (in_data[0]),
    .data_valid   (in_valid[0]),
    .data_ready   (in_ready[0]),
    .data_last    (in_last[0]),
    .grid_data    (in_data[1]),
    .grid_valid   (in_valid[1]),
    .grid_ready   (in_ready[1]),
    .grid_last    (in_last[1]),
    .scale_data   (in_data[2]),
    .scale_valid  (in_valid[2]),
    .scale_ready  (in_ready[2]),
    .scale_last   (in_last[2]),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_last  (result_last)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand_word();
    logic [31:0] v;
    v = rng_state;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    rng_state = v;
    return v;
  endfunction

  function automatic logic percent_hit(input int pct);
    return (rand_word() % 100) < pct;
  endfunction

  // sech2 of |scale * (x - grid)| with the product floored to 12 fraction bits
  function automatic mag_t expected_sech2(input sample_t x, input sample_t g, input sample_t s);
    longint diff;
    longint scaled;
    longint mag;
    diff   = longint'(x) - longint'(g);
    scaled = (diff * longint'(s)) >>> FRAC_BITS;
    mag    = (scaled < 0) ? -scaled : scaled;
    if (mag > 65535) begin
      mag = 65535;
    end
    if (mag >= 16384) begin
      return '0;
    end
    return lut_model[int'(mag / 256)];
  endfunction

  function automatic sample_t stream_value(input int s, input int idx);
    if (s == 0) begin
      return x_vals[idx];
    end
    if (s == 1) begin
      return g_vals[idx];
    end
    return s_vals[idx];
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    abort_run();
  endtask

  task automatic check_result(input string name, input mag_t expected, input mag_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: result expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: last expected %b, actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic push_item(inout int n, input sample_t x, input sample_t g,
                           input sample_t s, input logic last);
    x_vals[n]    = x;
    g_vals[n]    = g;
    s_vals[n]    = s;
    last_vals[n] = last;
    exp_vals[n]  = expected_sech2(x, g, s);
    n++;
  endtask

  task automatic load_random(input int n, input logic small_bias);
    int          frame_len;
    int          frame_pos;
    int          count;
    logic [15:0] offset;
    sample_t     x;
    sample_t     g;
    sample_t     s;
    frame_len = 1;
    frame_pos = 0;
    count     = 0;
    for (int i = 0; i < n; i++) begin
      if (frame_pos == 0) begin
        frame_len = 1 + int'(rand_word() % 9);
      end
      x = sample_t'(rand_word());
      if (small_bias && rand_word() % 4 != 0) begin
        // Grid within 1.0 of x and scale below 4.0
        offset = 16'(rand_word() % 8192) - 16'd4096;
        g      = x + offset;
        s      = sample_t'(rand_word() % 16384);
      end else begin
        g = sample_t'(rand_word());
        s = sample_t'(rand_word());
      end
      push_item(count, x, g, s, frame_pos == frame_len - 1);
      frame_pos = (frame_pos == frame_len - 1) ? 0 : frame_pos + 1;
    end
  endtask

  task automatic load_edges(output int n);
    sample_t d;
    n = 0;
    // Zero difference
    push_item(n, 16'h0000, 16'h0000, 16'h1000, 1'b0);
    push_item(n, 16'h1234, 16'h1234, 16'h7fff, 1'b0);
    push_item(n, 16'h8000, 16'h8000, 16'h8000, 1'b1);
    // Exactly 4.0, above it, and just under it
    push_item(n, 16'h4000, 16'h0000, 16'h1000, 1'b0);
    push_item(n, 16'h1000, 16'h0000, 16'h5000, 1'b0);
    push_item(n, 16'h3fff, 16'h0000, 16'h1000, 1'b1);
    // Products that saturate
    push_item(n, 16'h7fff, 16'h8000, 16'h7fff, 1'b0);
    push_item(n, 16'h8000, 16'h7fff, 16'h7fff, 1'b0);
    push_item(n, 16'h7fff, 16'h8000, 16'h8000, 1'b1);
    // Mirrored differences with a scale of 1.0 or -1.0 so the product stays exact
    for (int i = 0; i < 24; i++) begin
      d = sample_t'(rand_word() % 16384);
      push_item(n, d, 16'h0000, 16'h1000, 1'b0);
      push_item(n, 16'h0000, d, 16'h1000, 1'b0);
      push_item(n, d, 16'h0000, 16'hf000, 1'b1);
    end
  endtask

  // Called on the falling edge; readies only change on the rising edge
  task automatic drive_cycle(input string name, input int n, input int valid_pct,
                             input int ready_pct);
    for (int s = 0; s < 3; s++) begin
      if (!held[s]) begin
        if (sent[s] < n && percent_hit(valid_pct)) begin
          in_valid[s] = 1'b1;
          in_data[s]  = stream_value(s, sent[s]);
          in_last[s]  = last_vals[sent[s]];
        end else begin
          in_valid[s] = 1'b0;
        end
      end
      if (in_valid[s] && in_ready[s]) begin
        sent[s]++;
        held[s] = 1'b0;
      end else begin
        held[s] = in_valid[s];
      end
      if (!in_ready[s]) begin
        saw_full = 1'b1;
      end
    end
    result_ready = percent_hit(ready_pct);
    if (result_valid && result_ready) begin
      check_result($sformatf("%s item %0d", name, recv), exp_vals[recv], result_data);
      check_last($sformatf("%s item %0d", name, recv), last_vals[recv], result_last);
      recv++;
    end
  endtask

  task automatic check_idle(input string name);
    in_valid     = '0;
    held         = '0;
    result_ready = 1'b1;
    repeat (20) begin
      @(negedge clk);
      if (result_valid) begin
        report_failure($sformatf("%s: a result arrived after the last expected one", name));
      end
    end
  endtask

  task automatic run_items(input string name, input int n, input int valid_pct,
                           input int ready_pct);
    int cycles;
    int limit;
    for (int s = 0; s < 3; s++) begin
      sent[s] = 0;
    end
    held   = '0;
    recv   = 0;
    cycles = 0;
    limit  = 60 * n + 200;
    while (recv < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        report_failure($sformatf("%s: outputs stopped arriving after %0d of %0d results",
                                 name, recv, n));
      end
      drive_cycle(name, n, valid_pct, ready_pct);
    end
    check_idle(name);
  endtask

  initial begin
    int n_edge;
    rng_state    = 32'd76447;
    reset        = 1'b1;
    in_valid     = '0;
    in_last      = '0;
    held         = '0;
    recv         = 0;
    saw_full     = 1'b0;
    result_ready = 1'b0;
    for (int s = 0; s < 3; s++) begin
      in_data[s] = '0;
      sent[s]    = 0;
    end
    $readmemh(LUT_FILE, lut_model);
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("reset result_valid", 1'b0, result_valid);
    check_flag("reset data_ready", 1'b1, in_ready[0]);
    check_flag("reset grid_ready", 1'b1, in_ready[1]);
    check_flag("reset scale_ready", 1'b1, in_ready[2]);

    load_random(500, 1'b1);
    run_items("stream", 500, 100, 100);

    saw_full = 1'b0;
    load_random(800, 1'b1);
    run_items("backpressure", 800, 70, 50);
    if (!saw_full) begin
      report_failure("backpressure: no input ready ever dropped");
    end

    load_edges(n_edge);
    run_items("edges", n_edge, 80, 80);

    $display("Test passed");
    $finish;
  end

endmodule

// File: rswaf_function.f
hw/rswaf_pkg.sv
hw/axis_if.sv
hw/stream_fifo.sv
hw/scaled_diff.sv
hw/sech2_lut.sv
hw/rswaf_function.sv
bench/tb_rswaf_function.sv

// File: Makefile
# Verilator flow for the sech2 streaming function

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module tb_rswaf_function -f rswaf_function.f
	./obj_dir/Vtb_rswaf_function | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module rswaf_function -f rswaf_function.f

clean:
	rm -rf obj_dir sim.log

// File: hw/sech2_table.mem
// One Q4.12 word per line: sech2(i/16) for i = 0 to 63
1000
0ff0
0fc1
0f73
0f0a
0e89
0df2
0d4a
0c95
0bd7
0b14
0a4f
098c
08cc
0813
0761
06b8
061a
0585
04fc
047d
0408
039d
033c
02e4
0295
024d
020c
01d2
019e
0170
0146
0121
0100
00e3
00c9
00b2
009e
008b
007b
006d
0060
0055
004b
0042
003b
0034
002e
0028
0024
0020
001c
0019
0016
0013
0011
000f
000d
000c
000a
0009
0008
0007
0006
